// ==== build.f ====
design/l1_pkg.sv
design/req_arbiter.sv
design/l1_arrays.sv
design/mem_pipe.sv
design/mem_result.sv
design/l1_dcache_top.sv
verif/tb_l1_dcache.sv

// ==== Bender.yml ====
package:
  name: l1_dcache

sources:
  - design/l1_pkg.sv
  - design/req_arbiter.sv
  - design/l1_arrays.sv
  - design/mem_pipe.sv
  - design/mem_result.sv
  - design/l1_dcache_top.sv
  - target: test
    files:
      - verif/tb_l1_dcache.sv

// ==== verif/tb_l1_dcache.sv ====
module tb_l1_dcache
    import l1_pkg::*;
();

    localparam int SETS        = 16;
    localparam int WAYS        = 4;
    localparam int SET_W       = $clog2(SETS);
    localparam int TAG_W       = ADDR_W - OFFSET_W - SET_W;
    localparam int ITERS       = 16;
    // Prelude, priority groups and tail plus seven spaced requests per iteration
    localparam int STIM_CYCLES = 40 + ITERS * 7 * 4;
    localparam int TIMEOUT     = 4 * STIM_CYCLES;

    typedef struct packed {
        int                 due;
        logic               valid;
        logic               complete;
        logic               flq_alloc;
        logic               rob_complete;
        logic               reg_wr_en;
        logic [ROBID_W-1:0] robid;
        logic [PDST_W-1:0]  pdst;
        t_reg_data          data;
    } t_exp;

    logic               clk;
    logic               rst_n;
    logic               ld_req;
    t_mem_req           ld_pkt;
    logic               ld_gnt;
    logic               st_req;
    t_mem_req           st_pkt;
    logic               st_gnt;
    logic               fl_req;
    t_mem_req           fl_pkt;
    logic               fl_gnt;
    logic               flq_match;
    logic [ADDR_W-1:0]  flq_cam_addr;
    logic               result_valid;
    logic               complete;
    logic               recycle;
    logic               flq_alloc;
    logic               rob_complete;
    logic [ROBID_W-1:0] rob_id;
    logic               reg_wr_en;
    logic [PDST_W-1:0]  reg_wr_pdst;
    t_reg_data          reg_wr_data;

    // Reference model of the arrays
    // Only E or I ever appears
    logic               m_valid [SETS][WAYS];
    logic [TAG_W-1:0]   m_tag [SETS][WAYS];
    t_cl                m_line [SETS][WAYS];
    t_exp               exp_q [$];
    t_exp               exp_now = '0;
    logic               cam_chk = 1'b0;
    logic [ADDR_W-1:0]  cam_exp = '0;
    logic               flq_want = 1'b0;
    logic               flq_s1 = 1'b0;
    logic               flq_s2 = 1'b0;
    logic [31:0]        lfsr = 32'hc5ec;
    logic [ROBID_W-1:0] next_robid = '0;
    int                 cyc = 0;
    int                 granted = 0;
    int                 results = 0;

    l1_dcache_top #(.NUM_SETS(SETS), .NUM_WAYS(WAYS)) DUT (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    function automatic logic [127:0] rand_bits(input int n);
        logic [127:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            r[i] = lfsr[0];
        end
        return r;
    endfunction

    function automatic int find_way(input logic [ADDR_W-1:0] a);
        int r;
        r = -1;
        for (int w = 0; w < WAYS; w++) begin
            if (m_valid[a[OFFSET_W +: SET_W]][w]
                && m_tag[a[OFFSET_W +: SET_W]][w] == a[ADDR_W-1 -: TAG_W]) begin
                r = w;
            end
        end
        return r;
    endfunction

    // A present line is refilled in place so that no two ways share a tag
    function automatic t_way choose_way(input logic [ADDR_W-1:0] a);
        if (find_way(a) >= 0) return t_way'(find_way(a));
        return t_way'(rand_bits(2));
    endfunction

    function automatic logic [ADDR_W-1:0] absent_addr();
        logic [ADDR_W-1:0] a;
        a = ADDR_W'(rand_bits(ADDR_W));
        while (find_way(a) >= 0) begin
            a = ADDR_W'(rand_bits(ADDR_W));
        end
        return a;
    endfunction

    function automatic logic [ADDR_W-1:0] same_line(input logic [ADDR_W-1:0] a);
        return {a[ADDR_W-1:OFFSET_W], OFFSET_W'(rand_bits(OFFSET_W))};
    endfunction

    function automatic t_cl merge(input t_cl old, input t_cl nw, input t_cl_be be);
        t_cl r;
        r = old;
        for (int b = 0; b < LINE_BYTES; b++) begin
            if (be[b]) begin
                r[b] = nw[b];
            end
        end
        return r;
    endfunction

    // Eight bytes from the offset with wrap at the end of the line
    function automatic t_reg_data rotate(input t_cl line, input logic [OFFSET_W-1:0] off);
        t_reg_data r;
        for (int b = 0; b < 8; b++) begin
            r[8*b +: 8] = line[(int'(off) + b) % LINE_BYTES];
        end
        return r;
    endfunction

    function automatic logic [2:0] expected_gnts(input logic l, input logic s, input logic f);
        if (l) return 3'b001;
        if (s) return 3'b010;
        if (f) return 3'b100;
        return 3'b000;
    endfunction

    function automatic logic [5:0] exp_flags(input t_exp e);
        return {e.valid, e.complete, e.valid && !e.complete,
                e.flq_alloc, e.rob_complete, e.reg_wr_en};
    endfunction

    function automatic t_mem_req make_pkt(input t_mem_type kind, input t_st_phase phase,
                                          input logic [ADDR_W-1:0] addr, input t_way way,
                                          input t_cl data, input t_cl_be be);
        t_mem_req p;
        p.kind     = kind;
        p.phase    = phase;
        p.addr     = addr;
        p.way      = way;
        p.data     = data;
        p.byte_en  = be;
        p.robid    = next_robid;
        p.pdst     = PDST_W'(rand_bits(PDST_W));
        next_robid = next_robid + 1'b1;
        return p;
    endfunction

    task automatic raise(input t_mem_req p);
        case (p.kind)
            MEM_LOAD: begin
                ld_pkt = p;
                ld_req = 1'b1;
            end
            MEM_STORE: begin
                st_pkt = p;
                st_req = 1'b1;
            end
            default: begin
                fl_pkt = p;
                fl_req = 1'b1;
            end
        endcase
    endtask

    task automatic idle(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    // Hold requests until each one is granted
    task automatic drain_grants();
        logic [2:0] g;
        while (ld_req || st_req || fl_req) begin
            @(posedge clk);
            g = {fl_gnt, st_gnt, ld_gnt};
            #1;
            ld_req = ld_req && !g[0];
            st_req = st_req && !g[1];
            fl_req = fl_req && !g[2];
        end
    endtask

    task automatic send(input t_mem_req p, input logic flq);
        raise(p);
        flq_want = flq;
        drain_grants();
        idle(3);
    endtask

    // Model update and expected result at each grant
    always @(posedge clk) begin
        t_mem_req         p;
        t_exp             e;
        int               w;
        logic             hit;
        logic [SET_W-1:0] s;
        exp_now <= '0;
        cam_chk <= 1'b0;
        if (exp_q.size() != 0 && exp_q[0].due == cyc) begin
            exp_now <= exp_q.pop_front();
        end
        if (result_valid) begin
            results++;
        end
        flq_s2 <= flq_s1;
        flq_s1 <= flq_want;
        if (ld_gnt || st_gnt || fl_gnt) begin
            p              = ld_gnt ? ld_pkt : (st_gnt ? st_pkt : fl_pkt);
            s              = p.addr[OFFSET_W +: SET_W];
            w              = find_way(p.addr);
            hit            = w >= 0;
            e.due          = cyc + 4;
            e.valid        = 1'b1;
            e.complete     = p.kind == MEM_FILL || hit
                || (p.kind == MEM_STORE && p.phase == MEM_ST_INITIAL);
            e.flq_alloc    = p.kind != MEM_FILL && !hit && !flq_want;
            e.rob_complete = e.complete && (p.kind == MEM_LOAD
                || (p.kind == MEM_STORE && p.phase == MEM_ST_INITIAL));
            e.reg_wr_en    = e.complete && p.kind == MEM_LOAD;
            e.robid        = p.robid;
            e.pdst         = p.pdst;
            e.data         = hit ? rotate(m_line[s][w], p.addr[OFFSET_W-1:0]) : '0;
            exp_q.push_back(e);
            granted++;
            cam_chk <= 1'b1;
            cam_exp <= p.addr;
            if (p.kind == MEM_FILL) begin
                m_valid[s][p.way] = 1'b1;
                m_tag[s][p.way]   = p.addr[ADDR_W-1 -: TAG_W];
                m_line[s][p.way]  = merge(m_line[s][p.way], p.data, p.byte_en);
            end else if (p.kind == MEM_STORE && p.phase == MEM_ST_FINAL && hit) begin
                m_line[s][w] = merge(m_line[s][w], p.data, p.byte_en);
            end
        end
    end

    // Fill-queue match lines up with the request now in MM2
    always @(posedge clk) begin
        #1;
        flq_match = flq_s2;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= TIMEOUT) stop_on_error("Timeout: the run did not finish within the cycle limit");
    end

    a_gnts: assert property (@(posedge clk) disable iff (!rst_n)
        {fl_gnt, st_gnt, ld_gnt} == expected_gnts(ld_req, st_req, fl_req))
        else stop_on_error($sformatf("ERR {fl_gnt,st_gnt,ld_gnt} exp 0x%h got 0x%h",
            expected_gnts($sampled(ld_req), $sampled(st_req), $sampled(fl_req)),
            $sampled({fl_gnt, st_gnt, ld_gnt})));

    a_flags: assert property (@(posedge clk) disable iff (!rst_n)
        {result_valid, complete, recycle, flq_alloc, rob_complete, reg_wr_en}
            == exp_flags(exp_now))
        else stop_on_error($sformatf(
            "ERR {result_valid,complete,recycle,flq_alloc,rob_complete,reg_wr_en} exp 0x%h got 0x%h",
            exp_flags($sampled(exp_now)),
            $sampled({result_valid, complete, recycle, flq_alloc, rob_complete, reg_wr_en})));

    a_rob_id: assert property (@(posedge clk) disable iff (!rst_n)
        exp_now.valid |-> rob_id == exp_now.robid)
        else stop_on_error($sformatf("ERR rob_id exp 0x%h got 0x%h",
            $sampled(exp_now.robid), $sampled(rob_id)));

    a_pdst: assert property (@(posedge clk) disable iff (!rst_n)
        exp_now.reg_wr_en |-> reg_wr_pdst == exp_now.pdst)
        else stop_on_error($sformatf("ERR reg_wr_pdst exp 0x%h got 0x%h",
            $sampled(exp_now.pdst), $sampled(reg_wr_pdst)));

    a_data: assert property (@(posedge clk) disable iff (!rst_n)
        exp_now.reg_wr_en |-> reg_wr_data == exp_now.data)
        else stop_on_error($sformatf("ERR reg_wr_data exp 0x%h got 0x%h",
            $sampled(exp_now.data), $sampled(reg_wr_data)));

    // Request in MM1 offers its address to the fill queue
    a_cam_addr: assert property (@(posedge clk) disable iff (!rst_n)
        cam_chk |-> flq_cam_addr == cam_exp)
        else stop_on_error($sformatf("ERR flq_cam_addr exp 0x%h got 0x%h",
            $sampled(cam_exp), $sampled(flq_cam_addr)));

    initial begin
        logic [ADDR_W-1:0] a;
        for (int s = 0; s < SETS; s++) begin
            for (int w = 0; w < WAYS; w++) begin
                m_valid[s][w] = 1'b0;
            end
        end
        rst_n     = 1'b0;
        ld_req    = 1'b0;
        st_req    = 1'b0;
        fl_req    = 1'b0;
        ld_pkt    = '0;
        st_pkt    = '0;
        fl_pkt    = '0;
        flq_match = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        idle(8);

        // All three at once and then store against fill
        raise(make_pkt(MEM_LOAD, MEM_ST_INITIAL, 16'h1210, '0, '0, '0));
        raise(make_pkt(MEM_STORE, MEM_ST_INITIAL, 16'h3420, '0, rand_bits(128), '1));
        raise(make_pkt(MEM_FILL, MEM_ST_INITIAL, 16'h5630, 2'd1, rand_bits(128), '1));
        flq_want = 1'b0;
        drain_grants();
        idle(3);
        raise(make_pkt(MEM_STORE, MEM_ST_FINAL, 16'h7840, '0, rand_bits(128), '1));
        raise(make_pkt(MEM_FILL, MEM_ST_INITIAL, 16'h9a50, 2'd2, rand_bits(128), '1));
        drain_grants();
        idle(3);

        // Miss with a match in flight and then a wrapping hit
        send(make_pkt(MEM_LOAD, MEM_ST_INITIAL, 16'hbc64, '0, '0, '0), 1'b1);
        send(make_pkt(MEM_LOAD, MEM_ST_INITIAL, 16'h563c, '0, '0, '0), 1'b0);

        for (int i = 0; i < ITERS; i++) begin
            a = ADDR_W'(rand_bits(ADDR_W));
            send(make_pkt(MEM_FILL, MEM_ST_INITIAL, a, choose_way(a), rand_bits(128), '1), 1'b0);
            send(make_pkt(MEM_LOAD, MEM_ST_INITIAL, same_line(a), '0, '0, '0), 1'b0);
            send(make_pkt(MEM_STORE, MEM_ST_FINAL, same_line(a), '0, rand_bits(128),
                          t_cl_be'(rand_bits(LINE_BYTES))), 1'b0);
            send(make_pkt(MEM_LOAD, MEM_ST_INITIAL, same_line(a), '0, '0, '0), 1'b0);
            send(make_pkt(MEM_STORE, MEM_ST_INITIAL, absent_addr(), '0, rand_bits(128),
                          t_cl_be'(rand_bits(LINE_BYTES))), 1'(rand_bits(1)));
            send(make_pkt(MEM_STORE, MEM_ST_FINAL, absent_addr(), '0, rand_bits(128),
                          t_cl_be'(rand_bits(LINE_BYTES))), 1'(rand_bits(1)));
            send(make_pkt(MEM_LOAD, MEM_ST_INITIAL, absent_addr(), '0, '0, '0),
                 1'(rand_bits(1)));
        end
        idle(10);

        if (exp_q.size() != 0 || results != granted) begin
            stop_on_error("The number of results differs from the number of granted requests");
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

// ==== design/l1_dcache_top.sv ====
module l1_dcache_top
    import l1_pkg::*;
#(
    parameter int NUM_SETS = 16,
    parameter int NUM_WAYS = 4
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               ld_req,
    input  t_mem_req           ld_pkt,
    output logic               ld_gnt,
    input  logic               st_req,
    input  t_mem_req           st_pkt,
    output logic               st_gnt,
    input  logic               fl_req,
    input  t_mem_req           fl_pkt,
    output logic               fl_gnt,
    input  logic               flq_match,
    output logic [ADDR_W-1:0]  flq_cam_addr,
    output logic               result_valid,
    output logic               complete,
    output logic               recycle,
    output logic               flq_alloc,
    output logic               rob_complete,
    output logic [ROBID_W-1:0] rob_id,
    output logic               reg_wr_en,
    output logic [PDST_W-1:0]  reg_wr_pdst,
    output t_reg_data          reg_wr_data
);

    localparam int SET_W = $clog2(NUM_SETS);
    localparam int TAG_W = ADDR_W - OFFSET_W - SET_W;

    t_mem_req         req_pkts [3];
    logic             win_valid;
    t_mem_req         win_pkt;
    logic [SET_W-1:0] rd_set;
    logic             tag_rd_en;
    logic             state_rd_en;
    logic             data_rd_en;
    logic             tag_wr_en;
    logic             state_wr_en;
    logic [TAG_W-1:0] wr_tag;
    t_mesi            wr_state;
    t_way             meta_wr_way;
    logic [TAG_W-1:0] rd_tags [NUM_WAYS];
    t_mesi            rd_states [NUM_WAYS];
    t_cl              rd_lines [NUM_WAYS];
    logic             data_wr_en;
    logic [SET_W-1:0] data_wr_set;
    t_way             data_wr_way;
    t_cl              data_wr_line;
    t_cl_be           data_wr_be;
    logic             valid_mm5;
    t_mem_req         pkt_mm5;
    logic             hit_mm5;
    logic             flq_match_mm5;
    t_reg_data        load_data_mm5;

    // Index 0 has top priority
    assign req_pkts[0] = ld_pkt;
    assign req_pkts[1] = st_pkt;
    assign req_pkts[2] = fl_pkt;

    req_arbiter #(.NREQS(3), .T(t_mem_req)) u_arb (
        .clk,
        .rst_n,
        .req_valids ({fl_req, st_req, ld_req}),
        .req_pkts,
        .gnts       ({fl_gnt, st_gnt, ld_gnt}),
        .win_valid,
        .win_pkt
    );

    mem_pipe #(.NUM_SETS(NUM_SETS), .NUM_WAYS(NUM_WAYS)) u_pipe (.*);

    l1_arrays #(.NUM_SETS(NUM_SETS), .NUM_WAYS(NUM_WAYS)) u_arrays (.*);

    mem_result u_result (.*);

endmodule

// ==== design/mem_result.sv ====
module mem_result
    import l1_pkg::*;
(
    input  logic               valid_mm5,
    input  t_mem_req           pkt_mm5,
    input  logic               hit_mm5,
    input  logic               flq_match_mm5,
    input  t_reg_data          load_data_mm5,
    output logic               result_valid,
    output logic               complete,
    output logic               recycle,
    output logic               flq_alloc,
    output logic               rob_complete,
    output logic [ROBID_W-1:0] rob_id,
    output logic               reg_wr_en,
    output logic [PDST_W-1:0]  reg_wr_pdst,
    output t_reg_data          reg_wr_data
);

    logic is_ld;
    logic is_st;
    logic st_initial;

    assign is_ld      = pkt_mm5.kind == MEM_LOAD;
    assign is_st      = pkt_mm5.kind == MEM_STORE;
    assign st_initial = pkt_mm5.phase == MEM_ST_INITIAL;

    always_comb begin
        complete = 1'b0;
        if (valid_mm5) begin
            case (pkt_mm5.kind)
                MEM_FILL:  complete = 1'b1;
                MEM_LOAD:  complete = hit_mm5;
                // Initial phase only reserves, final phase needs ownership
                MEM_STORE: complete = st_initial || hit_mm5;
                default:   complete = 1'b0;
            endcase
        end
    end

    assign result_valid = valid_mm5;
    assign recycle      = valid_mm5 && !complete;
    // Miss with nothing already outstanding for the line
    assign flq_alloc    = valid_mm5 && (is_ld || is_st) && !hit_mm5 && !flq_match_mm5;

    assign rob_complete = complete && (is_ld || (is_st && st_initial));
    assign rob_id       = pkt_mm5.robid;

    assign reg_wr_en    = complete && is_ld;
    assign reg_wr_pdst  = pkt_mm5.pdst;
    assign reg_wr_data  = load_data_mm5;

endmodule

// ==== design/mem_pipe.sv ====
module mem_pipe
    import l1_pkg::*;
#(
    parameter int   NUM_SETS = 16,
    parameter int   NUM_WAYS = 4,
    localparam int  SET_W    = $clog2(NUM_SETS),
    localparam int  TAG_W    = ADDR_W - OFFSET_W - SET_W
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              win_valid,
    input  t_mem_req          win_pkt,
    input  logic              flq_match,
    output logic [ADDR_W-1:0] flq_cam_addr,
    output logic [SET_W-1:0]  rd_set,
    output logic              tag_rd_en,
    output logic              state_rd_en,
    output logic              data_rd_en,
    output logic              tag_wr_en,
    output logic              state_wr_en,
    output logic [TAG_W-1:0]  wr_tag,
    output t_mesi             wr_state,
    output t_way              meta_wr_way,
    input  logic [TAG_W-1:0]  rd_tags [NUM_WAYS],
    input  t_mesi             rd_states [NUM_WAYS],
    input  t_cl               rd_lines [NUM_WAYS],
    output logic              data_wr_en,
    output logic [SET_W-1:0]  data_wr_set,
    output t_way              data_wr_way,
    output t_cl               data_wr_line,
    output t_cl_be            data_wr_be,
    output logic              valid_mm5,
    output t_mem_req          pkt_mm5,
    output logic              hit_mm5,
    output logic              flq_match_mm5,
    output t_reg_data         load_data_mm5
);

    // Stage registers indexed by stage number
    logic                valid_q [1:5];
    t_mem_req            pkt_q   [1:5];
    logic                hit_q   [3:5];
    logic                flq_q   [3:5];
    logic                is_rd_mm1;
    logic                is_fl_mm1;
    logic [NUM_WAYS-1:0] hit_vec_mm2;
    logic [NUM_WAYS-1:0] hit_vec_mm3;
    t_cl                 lines_mm3 [NUM_WAYS];
    t_cl                 line_mm3;
    t_way                hit_way_mm3;
    t_cl                 line_mm4;
    t_reg_data           rot_mm4;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 1; s <= 5; s++) begin
                valid_q[s] <= 1'b0;
            end
            for (int s = 3; s <= 5; s++) begin
                hit_q[s] <= 1'b0;
            end
        end else begin
            valid_q[1] <= win_valid;
            for (int s = 2; s <= 5; s++) begin
                valid_q[s] <= valid_q[s-1];
            end
            hit_q[3] <= |hit_vec_mm2;
            hit_q[4] <= hit_q[3];
            hit_q[5] <= hit_q[4];
        end
    end

    always_ff @(posedge clk) begin
        pkt_q[1] <= win_pkt;
        for (int s = 2; s <= 5; s++) begin
            pkt_q[s] <= pkt_q[s-1];
        end
        flq_q[3]      <= flq_match;
        flq_q[4]      <= flq_q[3];
        flq_q[5]      <= flq_q[4];
        hit_vec_mm3   <= hit_vec_mm2;
        lines_mm3     <= rd_lines;
        line_mm4      <= line_mm3;
        load_data_mm5 <= rot_mm4;
    end

    // MM1: array access, loads and stores read, fills write metadata
    assign is_rd_mm1    = valid_q[1] && (pkt_q[1].kind inside {MEM_LOAD, MEM_STORE});
    assign is_fl_mm1    = valid_q[1] && (pkt_q[1].kind == MEM_FILL);
    assign rd_set       = pkt_q[1].addr[OFFSET_W +: SET_W];
    assign tag_rd_en    = is_rd_mm1;
    assign state_rd_en  = is_rd_mm1;
    assign data_rd_en   = is_rd_mm1;
    assign tag_wr_en    = is_fl_mm1;
    assign state_wr_en  = is_fl_mm1;
    assign wr_tag       = pkt_q[1].addr[ADDR_W-1 -: TAG_W];
    assign wr_state     = MESI_E;
    assign meta_wr_way  = pkt_q[1].way;
    assign flq_cam_addr = pkt_q[1].addr;

    // MM2: hit per way
    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            hit_vec_mm2[w] = valid_q[2]
                && (rd_tags[w] == pkt_q[2].addr[ADDR_W-1 -: TAG_W])
                && ((pkt_q[2].kind == MEM_LOAD && (rd_states[w] inside {MESI_S, MESI_E, MESI_M}))
                 || (pkt_q[2].kind == MEM_STORE && (rd_states[w] inside {MESI_E, MESI_M})));
        end
    end

    // MM3: way mux and data write
    always_comb begin
        line_mm3    = '0;
        hit_way_mm3 = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (hit_vec_mm3[w]) begin
                line_mm3    = line_mm3 | lines_mm3[w];
                hit_way_mm3 = t_way'(w);
            end
        end
    end

    assign data_wr_en = valid_q[3]
        && (pkt_q[3].kind == MEM_FILL
         || (pkt_q[3].kind == MEM_STORE && pkt_q[3].phase == MEM_ST_FINAL && hit_q[3]));
    assign data_wr_set  = pkt_q[3].addr[OFFSET_W +: SET_W];
    assign data_wr_way  = (pkt_q[3].kind == MEM_FILL) ? pkt_q[3].way : hit_way_mm3;
    assign data_wr_line = pkt_q[3].data;
    assign data_wr_be   = pkt_q[3].byte_en;

    // MM4: rotate to byte offset, wraps within the line
    always_comb begin
        logic [OFFSET_W-1:0] o;
        o = pkt_q[4].addr[OFFSET_W-1:0];
        for (int b = 0; b < 8; b++) begin
            rot_mm4[8*b +: 8] = line_mm4[o];
            o = o + 1'b1;
        end
    end

    assign valid_mm5     = valid_q[5];
    assign pkt_mm5       = pkt_q[5];
    assign hit_mm5       = hit_q[5];
    assign flq_match_mm5 = flq_q[5];

    a_hit_onehot: assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot0(hit_vec_mm2)
    );

endmodule

// ==== design/l1_arrays.sv ====
module l1_arrays
    import l1_pkg::*;
#(
    parameter int   NUM_SETS = 16,
    parameter int   NUM_WAYS = 4,
    localparam int  SET_W    = $clog2(NUM_SETS),
    localparam int  TAG_W    = ADDR_W - OFFSET_W - SET_W
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic [SET_W-1:0] rd_set,
    input  logic             tag_rd_en,
    input  logic             state_rd_en,
    input  logic             data_rd_en,
    input  logic             tag_wr_en,
    input  logic             state_wr_en,
    input  logic [TAG_W-1:0] wr_tag,
    input  t_mesi            wr_state,
    input  t_way             meta_wr_way,
    output logic [TAG_W-1:0] rd_tags [NUM_WAYS],
    output t_mesi            rd_states [NUM_WAYS],
    output t_cl              rd_lines [NUM_WAYS],
    input  logic             data_wr_en,
    input  logic [SET_W-1:0] data_wr_set,
    input  t_way             data_wr_way,
    input  t_cl              data_wr_line,
    input  t_cl_be           data_wr_be
);

    logic [TAG_W-1:0] tags   [NUM_SETS][NUM_WAYS];
    t_mesi            states [NUM_SETS][NUM_WAYS];
    t_cl              lines  [NUM_SETS][NUM_WAYS];

    // Metadata write shares the read set index
    always_ff @(posedge clk) begin
        if (tag_rd_en) begin
            rd_tags <= tags[rd_set];
        end
        if (state_rd_en) begin
            rd_states <= states[rd_set];
        end
        if (tag_wr_en) begin
            tags[rd_set][meta_wr_way] <= wr_tag;
        end
    end

    // All lines start invalid
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                for (int w = 0; w < NUM_WAYS; w++) begin
                    states[s][w] <= MESI_I;
                end
            end
        end else if (state_wr_en) begin
            states[rd_set][meta_wr_way] <= wr_state;
        end
    end

    always_ff @(posedge clk) begin
        if (data_rd_en) begin
            rd_lines <= lines[rd_set];
        end
        // Byte merge
        if (data_wr_en) begin
            for (int b = 0; b < LINE_BYTES; b++) begin
                if (data_wr_be[b]) begin
                    lines[data_wr_set][data_wr_way][b] <= data_wr_line[b];
                end
            end
        end
    end

    a_no_meta_rw: assert property (
        @(posedge clk) disable iff (!rst_n)
        !((tag_rd_en || state_rd_en) && (tag_wr_en || state_wr_en))
    );

endmodule

// ==== design/req_arbiter.sv ====
module req_arbiter #(
    parameter int  NREQS = 3,
    parameter type T     = logic
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic [NREQS-1:0] req_valids,
    input  T                 req_pkts [NREQS],
    output logic [NREQS-1:0] gnts,
    output logic             win_valid,
    output T                 win_pkt
);

    // Lowest index wins
    always_comb begin
        logic found;
        found   = 1'b0;
        gnts    = '0;
        win_pkt = req_pkts[0];
        for (int i = 0; i < NREQS; i++) begin
            if (req_valids[i] && !found) begin
                found   = 1'b1;
                gnts[i] = 1'b1;
                win_pkt = req_pkts[i];
            end
        end
    end

    assign win_valid = |req_valids;

    // Single winner, and a winner whenever anyone asks
    a_gnt_onehot: assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot0(gnts) && (win_valid == (|gnts))
    );

endmodule

// ==== design/l1_pkg.sv ====
package l1_pkg;

    // Physical address and line geometry
    localparam int ADDR_W     = 16;
    localparam int LINE_BYTES = 16;
    localparam int OFFSET_W   = $clog2(LINE_BYTES);

    localparam int ROBID_W = 6;
    localparam int PDST_W  = 6;

    typedef enum logic [1:0] {
        MEM_LOAD,
        MEM_STORE,
        MEM_FILL
    } t_mem_type;

    typedef enum logic {
        MEM_ST_INITIAL,
        MEM_ST_FINAL
    } t_st_phase;

    typedef enum logic [1:0] {
        MESI_I,
        MESI_S,
        MESI_E,
        MESI_M
    } t_mesi;

    // Line is byte addressable
    typedef logic [LINE_BYTES-1:0][7:0] t_cl;
    typedef logic [LINE_BYTES-1:0]      t_cl_be;
    typedef logic [63:0]                t_reg_data;
    // Sized for up to 4 ways
    typedef logic [1:0]                 t_way;

    typedef struct packed {
        t_mem_type           kind;
        t_st_phase           phase;
        logic [ADDR_W-1:0]   addr;
        t_way                way;      // fills only
        t_cl                 data;
        t_cl_be              byte_en;
        logic [ROBID_W-1:0]  robid;
        logic [PDST_W-1:0]   pdst;
    } t_mem_req;

endpackage
